/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert
TOP = lm80c_tb
FILELIST = compile.f
OBJ_DIR = obj_dir
PASS_TEXT = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/lm80c_checker.sv */
// LM80C glue bus assertions
`timescale 1ns/1ps

module lm80c_checker (
	input logic ram_clock,
	input logic RESET,
	input logic z80_ena_o,
	input logic vdp_ena_o,
	input logic vdp_csr_n_o,
	input logic vdp_csw_n_o
);

	// CPU enable is a subset of the video enable phases
	property z80_within_vdp;
		@(posedge ram_clock) disable iff (RESET)
			z80_ena_o |-> vdp_ena_o;
	endproperty

	// Enable stays low once reset has been seen for a full cycle
	property z80_quiet_in_reset;
		@(posedge ram_clock)
			(RESET && $past(RESET)) |-> !z80_ena_o;
	endproperty

	// VDP read and write strobes never overlap
	property vdp_strobes_exclusive;
		@(posedge ram_clock) disable iff (RESET)
			!(!vdp_csr_n_o && !vdp_csw_n_o);
	endproperty

	a_z80_within_vdp: assert property (z80_within_vdp)
		else $error("z80_ena_o high without vdp_ena_o");
	a_z80_quiet_in_reset: assert property (z80_quiet_in_reset)
		else $error("z80_ena_o high during RESET");
	a_vdp_strobes_exclusive: assert property (vdp_strobes_exclusive)
		else $error("vdp_csr_n_o and vdp_csw_n_o low together");

endmodule

/* bench/lm80c_tb.sv */
// LM80C glue testbench
`timescale 1ns/1ps
`include "lm80c_defs.svh"

module lm80c_tb import lm80c_pkg::*; ();

	localparam int CTRL_STEPS = 20;
	localparam int DL_COUNT = 32;
	localparam int WIN_COUNT = 40;
	localparam int IO_COUNT = 40;
	localparam int AUDIO_RUNS = 6;
	localparam int AUDIO_LEN = 1024;
	localparam int BUS_CYCLES = 10; // Hold, sample and idle of one access
	localparam int TOTAL_CYCLES = 30 + CTRL_STEPS * 2 + DL_COUNT + 10
		+ DL_COUNT * BUS_CYCLES + WIN_COUNT * 2 * BUS_CYCLES
		+ IO_COUNT * (BUS_CYCLES + 1) + 16 * BUS_CYCLES + 40
		+ AUDIO_RUNS * (AUDIO_LEN + 8);
	localparam int WATCHDOG_NS = TOTAL_CYCLES * 10 + 5000;

	logic ram_clock, RESET;
	logic boot_completed, reset_key, downloading, download_wr;
	addr_t download_addr, addr;
	byte_t download_data, cpu_dout, ctc_dout, vdp_dout, psg_dout;
	byte_t channel_a, channel_b, channel_c;
	logic rd_n, wr_n, iorq_n, mreq_n, m1_n, int_n;
	logic z80_ena, vdp_ena, sys_reset, cpu_wait, ctc_sel;
	logic vdp_csr_n, vdp_csw_n, psg_bdir, psg_bc, led, audio_l, audio_r;
	byte_t cpu_din;

	integer seed = 32'h4535_37ac;
	byte_t model_mem [0:65535]; // Reference RAM image
	byte_t model_latch; // Reference LED latch
	addr_t dl_addrs [$];
	addr_t win_addrs [$];

	lm80c_glue dut0 (
		.ram_clock(ram_clock), .RESET(RESET),
		.boot_completed_i(boot_completed), .reset_key_i(reset_key),
		.downloading_i(downloading), .download_wr_i(download_wr),
		.download_addr_i(download_addr), .download_data_i(download_data),
		.addr_i(addr), .cpu_dout_i(cpu_dout), .rd_n_i(rd_n), .wr_n_i(wr_n),
		.iorq_n_i(iorq_n), .mreq_n_i(mreq_n), .m1_n_i(m1_n), .int_n_i(int_n),
		.ctc_dout_i(ctc_dout), .vdp_dout_i(vdp_dout), .psg_dout_i(psg_dout),
		.channel_a_i(channel_a), .channel_b_i(channel_b), .channel_c_i(channel_c),
		.z80_ena_o(z80_ena), .vdp_ena_o(vdp_ena), .sys_reset_o(sys_reset),
		.cpu_wait_o(cpu_wait), .ctc_sel_o(ctc_sel), .vdp_csr_n_o(vdp_csr_n),
		.vdp_csw_n_o(vdp_csw_n), .psg_bdir_o(psg_bdir), .psg_bc_o(psg_bc),
		.cpu_din_o(cpu_din), .led_o(led), .audio_l_o(audio_l), .audio_r_o(audio_r)
	);

	bind lm80c_glue lm80c_checker chk0 (
		.ram_clock(ram_clock), .RESET(RESET), .z80_ena_o(z80_ena_o),
		.vdp_ena_o(vdp_ena_o), .vdp_csr_n_o(vdp_csr_n_o), .vdp_csw_n_o(vdp_csw_n_o)
	);

	always #5 ram_clock = ~ram_clock; // 10 ns period

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	function automatic byte_t rand8();
		logic [31:0] r;
		r = rand32();
		return r[7:0];
	endfunction

	function automatic addr_t rand16();
		logic [31:0] r;
		r = rand32();
		return r[15:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error %s: got %h, expected %h", name, actual, expected);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// Drive one bus cycle and sample at its end at N+6
	task automatic bus_access(input addr_t a, input logic rd, input logic wr,
		input logic iorq, input logic mreq, input logic m1, input byte_t d);
		@(posedge ram_clock);
		addr <= a;
		rd_n <= rd;
		wr_n <= wr;
		iorq_n <= iorq;
		mreq_n <= mreq;
		m1_n <= m1;
		cpu_dout <= d;
		repeat (6) @(posedge ram_clock);
		@(negedge ram_clock);
	endtask

	task automatic bus_idle();
		@(posedge ram_clock);
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		m1_n <= 1'b1;
		repeat (2) @(posedge ram_clock); // Lets the acknowledge pulse drop
	endtask

	task automatic mem_write(input addr_t a, input byte_t d);
		bus_access(a, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, d);
		if (a >= `RAM_WIN_LO && a <= `RAM_WIN_HI)
			model_mem[a] = d; // Writes outside the window are dropped
		bus_idle();
	endtask

	task automatic mem_read(input addr_t a);
		bus_access(a, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h00);
		check_value("cpu_din_o", 32'(cpu_din), 32'(model_mem[a]));
		bus_idle();
	endtask

	function automatic byte_t io_expected(input addr_t a);
		if (a[7:0] == `LED_PORT)
			return model_latch;
		case (a[7:4])
			`IO_CTC: return ctc_dout;
			`IO_VDP: return vdp_dout;
			`IO_PSG: return psg_dout;
			default: return 8'h00; // PIO and SIO read as zero
		endcase
	endfunction

	task automatic check_strobes(input addr_t a, input logic is_write);
		logic [3:0] g;
		g = a[7:4];
		check_value("ctc_sel_o", 32'(ctc_sel), 32'(g == `IO_CTC));
		check_value("vdp_csr_n_o", 32'(vdp_csr_n), 32'(!(!is_write && g == `IO_VDP)));
		check_value("vdp_csw_n_o", 32'(vdp_csw_n), 32'(!(is_write && g == `IO_VDP)));
		check_value("psg_bdir_o", 32'(psg_bdir), 32'(is_write && g == `IO_PSG));
		check_value("psg_bc_o", 32'(psg_bc), 32'(g == `IO_PSG && !a[0]));
	endtask

	task automatic io_read(input addr_t a);
		bus_access(a, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 8'h00);
		check_value("cpu_din_o", 32'(cpu_din), 32'(io_expected(a)));
		check_strobes(a, 1'b0);
		bus_idle();
	endtask

	task automatic io_write(input addr_t a, input byte_t d);
		bus_access(a, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, d);
		if (a[7:0] == `LED_PORT)
			model_latch = d;
		check_strobes(a, 1'b1);
		bus_idle();
	endtask

	// Interrupt acknowledge with the CTC placing a vector on the bus
	task automatic int_ack_cycle(input byte_t vec);
		@(posedge ram_clock);
		ctc_dout <= vec;
		bus_access(rand16(), 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 8'h00);
		check_value("cpu_din_o", 32'(cpu_din), 32'(vec));
		bus_idle();
	endtask

	task automatic pulse_int();
		@(posedge ram_clock);
		int_n <= 1'b1;
		repeat (3) @(posedge ram_clock);
		int_n <= 1'b0; // Watcher goes to PENDING
		repeat (3) @(posedge ram_clock);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the simulation ran longer than the tests should take");
		$display("Test failures found");
		$fatal(1);
	end

	initial begin
		byte_t d, v, ca, cb, cc;
		addr_t a;
		logic b, k, dl;
		int count, ideal, diff, idx;
		ram_clock = 1'b0;
		RESET = 1'b1;
		boot_completed = 1'b0;
		reset_key = 1'b0;
		downloading = 1'b0;
		download_wr = 1'b0;
		download_addr = '0;
		download_data = '0;
		addr = '0;
		cpu_dout = '0;
		{rd_n, wr_n, iorq_n, mreq_n, m1_n, int_n} = 6'b111111;
		ctc_dout = '0;
		vdp_dout = '0;
		psg_dout = '0;
		channel_a = '0;
		channel_b = '0;
		channel_c = '0;
		model_latch = '0;
		repeat (5) @(posedge ram_clock);
		RESET <= 1'b0;

		// Enables from phase 0 onwards
		for (int c = 0; c < 16; c++) begin
			@(posedge ram_clock);
			@(negedge ram_clock);
			check_value("z80_ena_o", 32'(z80_ena), 32'(c % 4 == 0));
			check_value("vdp_ena_o", 32'(vdp_ena), 32'(c % 2 == 0));
		end

		// Reset and wait one cycle behind the levels
		for (int i = 0; i < CTRL_STEPS; i++) begin
			d = rand8();
			b = d[0];
			k = d[1];
			dl = d[2];
			@(posedge ram_clock);
			boot_completed <= b;
			reset_key <= k;
			downloading <= dl;
			@(posedge ram_clock);
			@(negedge ram_clock);
			check_value("sys_reset_o", 32'(sys_reset), 32'(!b || k));
			check_value("cpu_wait_o", 32'(cpu_wait), 32'(!b || dl));
		end
		@(posedge ram_clock);
		boot_completed <= 1'b1;
		reset_key <= 1'b0;
		downloading <= 1'b0;
		repeat (4) @(posedge ram_clock);

		// Download to random addresses with some in the window
		downloading <= 1'b1;
		for (int i = 0; i < DL_COUNT; i++) begin
			a = rand16();
			if (i % 4 == 0)
				a[15:14] = 2'b10;
			d = rand8();
			@(posedge ram_clock);
			download_wr <= 1'b1;
			download_addr <= a;
			download_data <= d;
			model_mem[a] = d;
			dl_addrs.push_back(a);
		end
		@(posedge ram_clock);
		download_wr <= 1'b0;
		repeat (2) @(posedge ram_clock);
		downloading <= 1'b0;
		repeat (2) @(posedge ram_clock);
		foreach (dl_addrs[i])
			mem_read(dl_addrs[i]);

		// CPU writes with half of them aimed at downloaded bytes
		for (int i = 0; i < WIN_COUNT; i++) begin
			if (i % 2 == 0) begin
				a = rand16();
				a[15:14] = 2'b10;
			end else begin
				idx = int'(rand16()) % dl_addrs.size();
				a = dl_addrs[idx];
			end
			mem_write(a, rand8());
			win_addrs.push_back(a);
		end
		foreach (win_addrs[i])
			mem_read(win_addrs[i]);

		// I/O groups with alternating read and write
		for (int i = 0; i < IO_COUNT; i++) begin
			a = rand16();
			d = rand8();
			a[7:4] = 4'(d % 5);
			@(posedge ram_clock);
			ctc_dout <= rand8();
			vdp_dout <= rand8();
			psg_dout <= rand8();
			if (i % 2 == 0)
				io_read(a);
			else
				io_write(a, rand8());
		end

		// LED port write and readback
		d = rand8();
		io_write({rand8(), `LED_PORT}, d);
		io_read({rand8(), `LED_PORT});
		check_value("led_o", 32'(led), 32'(d != 8'h00));

		// Two acknowledges ending in the match vector light the LED
		pulse_int();
		int_ack_cycle(rand8());
		int_ack_cycle(`CTC_MATCH_VECTOR);
		model_latch = 8'h01;
		io_read(16'h00FF);
		check_value("led_o", 32'(led), 32'd1);

		// Wrong vector keeps the written byte
		d = rand8() | 8'h80;
		io_write(16'h00FF, d);
		pulse_int();
		int_ack_cycle(rand8());
		v = rand8();
		if (v == `CTC_MATCH_VECTOR)
			v = v + 8'd1;
		int_ack_cycle(v);
		io_read(16'h00FF);
		@(posedge ram_clock);
		int_n <= 1'b1;

		// Pulse density of the DAC bitstream
		for (int r = 0; r < AUDIO_RUNS; r++) begin
			ca = rand8();
			cb = rand8();
			cc = rand8();
			@(posedge ram_clock);
			channel_a <= ca;
			channel_b <= cb;
			channel_c <= cc;
			repeat (4) @(posedge ram_clock);
			count = 0;
			repeat (AUDIO_LEN) begin
				@(negedge ram_clock);
				check_value("audio_r_o", 32'(audio_r), 32'(audio_l));
				count += int'(audio_l);
			end
			ideal = ((int'(ca) + int'(cb) + int'(cc)) * 64 * AUDIO_LEN) / 65536;
			diff = count - ideal;
			if (diff < -1 || diff > 1)
				check_value("audio_l_o ones", 32'(count), 32'(ideal));
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

/* compile.f */
+incdir+hw
hw/lm80c_pkg.sv
hw/sys_control.sv
hw/io_decoder.sv
hw/sysram_port.sv
hw/led_port.sv
hw/audio_dac.sv
hw/lm80c_glue.sv
bench/lm80c_checker.sv
bench/lm80c_tb.sv

/* hw/audio_dac.sv */
// PSG channel mixer and sigma-delta DAC
`timescale 1ns/1ps
`include "lm80c_defs.svh"

module audio_dac import lm80c_pkg::*; (
	input logic ram_clock,
	input logic RESET,
	input byte_t channel_a_i,
	input byte_t channel_b_i,
	input byte_t channel_c_i,
	output logic audio_l_o,
	output logic audio_r_o
);

	mix_t mix_q; // Registered channel sum
	dac_word_t dac_word;
	logic [`DAC_BITS:0] acc; // Accumulator plus carry

	assign dac_word = {mix_q, 6'd0}; // Full-scale at 16 bits

	always_ff @(posedge ram_clock) begin
		mix_q <= mix_t'(channel_a_i) + mix_t'(channel_b_i) + mix_t'(channel_c_i);
	end

	// First-order modulator, carry is the bitstream
	always_ff @(posedge ram_clock) begin
		if (RESET)
			acc <= '0;
		else
			acc <= {1'b0, acc[`DAC_BITS-1:0]} + {1'b0, dac_word};
	end

	assign audio_l_o = acc[`DAC_BITS];
	assign audio_r_o = acc[`DAC_BITS]; // Mono mix on both sides

endmodule

/* hw/io_decoder.sv */
// I/O decode and CPU read-data mux
`timescale 1ns/1ps
`include "lm80c_defs.svh"

module io_decoder import lm80c_pkg::*; (
	input logic ram_clock,
	input logic sys_reset_i,
	input addr_t addr_i,
	input logic rd_n_i,
	input logic wr_n_i,
	input logic iorq_n_i,
	input logic mreq_n_i,
	input logic m1_n_i,
	input byte_t ctc_dout_i,
	input byte_t vdp_dout_i,
	input byte_t psg_dout_i,
	input byte_t ram_q_i,
	input byte_t led_latch_i,
	output logic ctc_sel_o,
	output logic vdp_csr_n_o,
	output logic vdp_csw_n_o,
	output logic psg_bdir_o,
	output logic psg_bc_o,
	output logic led_wr_o,
	output logic int_ack_o,
	output byte_t cpu_din_o
);

	logic io_cycle; // IORQ without MREQ
	logic pio_hit, ctc_hit, sio_hit, vdp_hit, psg_hit, led_hit;
	logic pio_sel, sio_sel, vdp_sel, psg_sel, led_sel;
	logic rd_q; // Registered read strobe

	assign io_cycle = ~iorq_n_i & mreq_n_i;
	assign pio_hit = io_cycle && (addr_i[7:4] == `IO_PIO);
	assign ctc_hit = io_cycle && (addr_i[7:4] == `IO_CTC);
	assign sio_hit = io_cycle && (addr_i[7:4] == `IO_SIO);
	assign vdp_hit = io_cycle && (addr_i[7:4] == `IO_VDP);
	assign psg_hit = io_cycle && (addr_i[7:4] == `IO_PSG);
	assign led_hit = io_cycle && (addr_i[7:0] == `LED_PORT);

	// Selects and strobes, all one cycle after the bus
	always_ff @(posedge ram_clock) begin
		if (sys_reset_i) begin
			pio_sel <= 1'b0;
			ctc_sel_o <= 1'b0;
			sio_sel <= 1'b0;
			vdp_sel <= 1'b0;
			psg_sel <= 1'b0;
			led_sel <= 1'b0;
			vdp_csr_n_o <= 1'b1;
			vdp_csw_n_o <= 1'b1;
			psg_bdir_o <= 1'b0;
			psg_bc_o <= 1'b0;
			led_wr_o <= 1'b0;
			int_ack_o <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			pio_sel <= pio_hit;
			ctc_sel_o <= ctc_hit;
			sio_sel <= sio_hit;
			vdp_sel <= vdp_hit;
			psg_sel <= psg_hit;
			led_sel <= led_hit;
			vdp_csr_n_o <= rd_n_i | ~vdp_hit;
			vdp_csw_n_o <= wr_n_i | ~vdp_hit;
			psg_bdir_o <= ~wr_n_i & psg_hit; // Latch/write when BDIR high
			psg_bc_o <= ~addr_i[0] & psg_hit; // Even port selects register address
			led_wr_o <= ~wr_n_i & led_hit;
			int_ack_o <= ~iorq_n_i & ~m1_n_i; // Interrupt acknowledge
			rd_q <= ~rd_n_i;
		end
	end

	// Read data, reloaded every cycle of a read
	// RAM data arrives one cycle after I/O data
	always_ff @(posedge ram_clock) begin
		if (rd_q) begin
			if (pio_sel || sio_sel)
				cpu_din_o <= '0; // No PIO or SIO behind these
			else if (ctc_sel_o)
				cpu_din_o <= ctc_dout_i;
			else if (vdp_sel)
				cpu_din_o <= vdp_dout_i;
			else if (psg_sel)
				cpu_din_o <= psg_dout_i;
			else if (led_sel)
				cpu_din_o <= led_latch_i;
			else
				cpu_din_o <= ram_q_i;
		end else if (int_ack_o) begin
			cpu_din_o <= ctc_dout_i; // Vector from the CTC
		end
	end

endmodule

/* hw/led_port.sv */
// LED peripheral with acknowledge watcher
`timescale 1ns/1ps
`include "lm80c_defs.svh"

module led_port import lm80c_pkg::*; (
	input logic ram_clock,
	input logic sys_reset_i,
	input logic z80_ena_i,
	input logic int_n_i,
	input logic int_ack_i,
	input logic led_wr_i,
	input byte_t ctc_dout_i,
	input byte_t cpu_dout_i,
	output byte_t led_latch_o,
	output logic led_o
);

	led_state_t state;
	logic ack_step; // One step per acknowledge cycle
	logic ack_used; // Current acknowledge already consumed

	assign ack_step = int_ack_i & z80_ena_i & ~ack_used;

	always_ff @(posedge ram_clock) begin
		if (sys_reset_i) begin
			state <= IDLE;
			ack_used <= 1'b0;
			led_latch_o <= '0;
			led_o <= 1'b0;
		end else begin
			led_o <= (led_latch_o != '0);
			if (!int_ack_i)
				ack_used <= 1'b0; // Re-arm for the next cycle
			case (state)
				IDLE: if (int_n_i) state <= ARMED;
				ARMED: if (!int_n_i) state <= PENDING;
				PENDING: if (ack_step) begin
					state <= ACKED;
					ack_used <= 1'b1;
				end
				ACKED: if (ack_step) begin
					ack_used <= 1'b1;
					if (ctc_dout_i == `CTC_MATCH_VECTOR) begin
						state <= MATCHED;
						led_latch_o <= 8'd1; // Light on match
					end
				end
				default: state <= IDLE; // MATCHED, watch again
			endcase
			if (led_wr_i)
				led_latch_o <= cpu_dout_i; // Port write held until reset or match
		end
	end

endmodule

/* hw/lm80c_defs.svh */
// LM80C glue constants
`ifndef LM80C_DEFS_SVH
`define LM80C_DEFS_SVH

// Upper nibble of the I/O address per device group
`define IO_PIO 4'h0
`define IO_CTC 4'h1
`define IO_SIO 4'h2
`define IO_VDP 4'h3
`define IO_PSG 4'h4

`define LED_PORT 8'hFF // Debug LED peripheral

// CPU-writable RAM window
`define RAM_WIN_LO 16'h8000
`define RAM_WIN_HI 16'hBFFF

`define CTC_MATCH_VECTOR 8'h46 // Vector that lights the LED
`define PHASES 8 // Clock phases per enable cycle
`define DAC_BITS 16 // DAC input width

`endif

/* hw/lm80c_glue.sv */
// LM80C system glue top level
`timescale 1ns/1ps

module lm80c_glue (
	input logic ram_clock,
	input logic RESET,
	input logic boot_completed_i,
	input logic reset_key_i,
	input logic downloading_i,
	input logic download_wr_i,
	input logic [15:0] download_addr_i,
	input logic [7:0] download_data_i,
	input logic [15:0] addr_i, // Z80 bus
	input logic [7:0] cpu_dout_i,
	input logic rd_n_i,
	input logic wr_n_i,
	input logic iorq_n_i,
	input logic mreq_n_i,
	input logic m1_n_i,
	input logic int_n_i,
	input logic [7:0] ctc_dout_i, // Peripheral read data
	input logic [7:0] vdp_dout_i,
	input logic [7:0] psg_dout_i,
	input logic [7:0] channel_a_i, // PSG audio channels
	input logic [7:0] channel_b_i,
	input logic [7:0] channel_c_i,
	output logic z80_ena_o,
	output logic vdp_ena_o,
	output logic sys_reset_o,
	output logic cpu_wait_o,
	output logic ctc_sel_o,
	output logic vdp_csr_n_o,
	output logic vdp_csw_n_o,
	output logic psg_bdir_o,
	output logic psg_bc_o,
	output logic [7:0] cpu_din_o,
	output logic led_o,
	output logic audio_l_o,
	output logic audio_r_o
);

	logic [7:0] ram_q; // RAM read data to the mux
	logic [7:0] led_latch;
	logic led_wr; // CPU write to LED port
	logic int_ack;

	sys_control u_sys_control (
		.ram_clock(ram_clock), .RESET(RESET),
		.boot_completed_i(boot_completed_i), .reset_key_i(reset_key_i),
		.downloading_i(downloading_i),
		.z80_ena_o(z80_ena_o), .vdp_ena_o(vdp_ena_o),
		.sys_reset_o(sys_reset_o), .cpu_wait_o(cpu_wait_o)
	);

	io_decoder u_io_decoder (
		.ram_clock(ram_clock), .sys_reset_i(sys_reset_o), .addr_i(addr_i),
		.rd_n_i(rd_n_i), .wr_n_i(wr_n_i), .iorq_n_i(iorq_n_i),
		.mreq_n_i(mreq_n_i), .m1_n_i(m1_n_i),
		.ctc_dout_i(ctc_dout_i), .vdp_dout_i(vdp_dout_i), .psg_dout_i(psg_dout_i),
		.ram_q_i(ram_q), .led_latch_i(led_latch),
		.ctc_sel_o(ctc_sel_o), .vdp_csr_n_o(vdp_csr_n_o), .vdp_csw_n_o(vdp_csw_n_o),
		.psg_bdir_o(psg_bdir_o), .psg_bc_o(psg_bc_o),
		.led_wr_o(led_wr), .int_ack_o(int_ack), .cpu_din_o(cpu_din_o)
	);

	sysram_port u_sysram_port (
		.ram_clock(ram_clock), .addr_i(addr_i), .cpu_dout_i(cpu_dout_i),
		.wr_n_i(wr_n_i), .mreq_n_i(mreq_n_i),
		.downloading_i(downloading_i), .download_wr_i(download_wr_i),
		.download_addr_i(download_addr_i), .download_data_i(download_data_i),
		.ram_q_o(ram_q)
	);

	led_port u_led_port (
		.ram_clock(ram_clock), .sys_reset_i(sys_reset_o), .z80_ena_i(z80_ena_o),
		.int_n_i(int_n_i), .int_ack_i(int_ack), .led_wr_i(led_wr),
		.ctc_dout_i(ctc_dout_i), .cpu_dout_i(cpu_dout_i),
		.led_latch_o(led_latch), .led_o(led_o)
	);

	audio_dac u_audio_dac (
		.ram_clock(ram_clock), .RESET(RESET),
		.channel_a_i(channel_a_i), .channel_b_i(channel_b_i),
		.channel_c_i(channel_c_i),
		.audio_l_o(audio_l_o), .audio_r_o(audio_r_o)
	);

endmodule

/* hw/lm80c_pkg.sv */
// LM80C glue types

package lm80c_pkg;

	typedef logic [15:0] addr_t; // Z80 address
	typedef logic [7:0] byte_t; // Data byte
	typedef logic [9:0] mix_t; // Sum of three 8-bit channels
	typedef logic [15:0] dac_word_t; // Mix scaled to DAC range
	typedef logic [2:0] phase_t; // Position within the 8-phase cycle

	// Interrupt-acknowledge watcher
	typedef enum logic [2:0] {
		IDLE,
		ARMED, // INT_n seen high
		PENDING, // INT_n asserted
		ACKED, // First acknowledge taken
		MATCHED // Vector matched, LED lit
	} led_state_t;

endpackage

/* hw/sys_control.sv */
// Clock enables, system reset and CPU wait
`timescale 1ns/1ps

module sys_control import lm80c_pkg::*; (
	input logic ram_clock,
	input logic RESET,
	input logic boot_completed_i,
	input logic reset_key_i,
	input logic downloading_i,
	output logic z80_ena_o,
	output logic vdp_ena_o,
	output logic sys_reset_o,
	output logic cpu_wait_o
);

	phase_t phase; // Free-running phase counter

	// Enables are registered from the phase, so they line up with phase 0
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			phase <= '0;
			z80_ena_o <= 1'b0;
			vdp_ena_o <= 1'b0;
		end else begin
			phase <= phase + 3'd1;
			z80_ena_o <= (phase[1:0] == 2'd0); // Phases 0 and 4
			vdp_ena_o <= ~phase[0]; // Even phases
		end
	end

	// Reset while booting or on the reset key
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			sys_reset_o <= 1'b1;
		end else begin
			sys_reset_o <= ~boot_completed_i | reset_key_i;
		end
	end

	// CPU stalled until boot is done and while a download runs
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_wait_o <= 1'b1;
		end else begin
			cpu_wait_o <= ~boot_completed_i | downloading_i;
		end
	end

endmodule

/* hw/sysram_port.sv */
// System RAM with download arbitration
`timescale 1ns/1ps
`include "lm80c_defs.svh"

module sysram_port import lm80c_pkg::*; (
	input logic ram_clock,
	input addr_t addr_i,
	input byte_t cpu_dout_i,
	input logic wr_n_i,
	input logic mreq_n_i,
	input logic downloading_i,
	input logic download_wr_i,
	input addr_t download_addr_i,
	input byte_t download_data_i,
	output byte_t ram_q_o
);

	byte_t mem [0:65535]; // 64 KiB system RAM

	addr_t ram_addr;
	byte_t ram_din;
	logic ram_we;
	logic in_window; // CPU address inside writable area

	assign in_window = (addr_i >= `RAM_WIN_LO) && (addr_i <= `RAM_WIN_HI);

	// Downloader owns the RAM while active
	always_ff @(posedge ram_clock) begin
		if (downloading_i) begin
			ram_addr <= download_addr_i;
			ram_din <= download_data_i;
			ram_we <= download_wr_i; // Any address allowed
		end else begin
			ram_addr <= addr_i;
			ram_din <= cpu_dout_i;
			ram_we <= ~wr_n_i & ~mreq_n_i & in_window;
		end
	end

	// Synchronous array, read returns old data on a write
	always_ff @(posedge ram_clock) begin
		if (ram_we)
			mem[ram_addr] <= ram_din;
		ram_q_o <= mem[ram_addr];
	end

endmodule
